// File: bench/gmii_rx_mac_sva.sv
// ------------------------------
// Output stream assertions for the receive MAC, bound onto the top level
// ------------------------------
module gmii_rx_mac_sva
(
	input logic                 eth_clk,
	input logic                 eth_sresetn,
	input eth_rx_pkg::rx_beat_t i_beat,
	input logic                 i_valid,
	input logic                 i_ready
);

	// Output register comes out of reset empty
	assert property (@(posedge eth_clk) !eth_sresetn |=> !i_valid)
		else $error("o_valid is high in the cycle after reset");

	// A stalled beat stays offered and unchanged
	assert property (@(posedge eth_clk) disable iff (!eth_sresetn)
		(i_valid && !i_ready) |=> (i_valid && $stable(i_beat)))
		else $error("o_beat or o_valid changed while stalled");

	// Every offered beat carries at least one byte
	assert property (@(posedge eth_clk) disable iff (!eth_sresetn)
		i_valid |-> (i_beat.keep != '0))
		else $error("o_valid high with an empty keep");

endmodule

bind gmii_rx_mac gmii_rx_mac_sva sva_i
(
	.eth_clk     (eth_clk),
	.eth_sresetn (eth_sresetn),
	.i_beat      (o_beat),
	.i_valid     (o_valid),
	.i_ready     (i_ready)
);

// File: bench/gmii_rx_mac_tb.sv
// ------------------------------
// Testbench for the receive MAC with random GMII frames in and beats checked against a model
// Phases cover good, malformed, errored and overflowing frames
// ------------------------------
module gmii_rx_mac_tb;

	localparam int LOG2_DEPTH = 5;
	localparam int DEPTH      = 1 << LOG2_DEPTH;
	localparam int NB         = eth_rx_pkg::RX_BYTES;
	localparam int MAX_LEN    = 40;
	// Outstanding beats allowed before a frame so that one more frame always fits
	localparam int ROOM       = DEPTH - (MAX_LEN + NB - 1) / NB;
	localparam int TIMEOUT    = 4000;

	// Frame kinds
	localparam int K_GOOD      = 0;
	localparam int K_RXERR     = 1;
	localparam int K_BAD_FIRST = 2;
	localparam int K_BAD_MID   = 3;
	localparam int K_NO_SFD    = 4;

	// Downstream ready modes
	localparam int READY_RANDOM = 0;
	localparam int READY_LOW    = 1;
	localparam int READY_HIGH   = 2;

	logic                 eth_clk;
	logic                 eth_sresetn;
	logic [7:0]           i_rxd;
	logic                 i_rxdv;
	logic                 i_rxer;
	logic                 i_ready;
	eth_rx_pkg::rx_beat_t o_beat;
	logic                 o_valid;
	logic [15:0]          o_frame_count;
	logic [15:0]          o_drop_count;

	int seed       = 32'h37361a7c;
	int ready_seed = 32'h37361a7c;
	int ready_mode = READY_RANDOM;
	int ready_rnd;

	// Model state with expected beats in delivery order
	eth_rx_pkg::rx_beat_t exp_q[$];
	int                   taken = 0;
	logic [15:0]          exp_frames;
	logic [15:0]          exp_drops;
	logic [15:0]          stall_frames;
	int                   space_used;
	bit                   out_reg_used;
	int                   sent_beats;

	// Beat seen stalled on the previous edge
	logic                 held_valid = 1'b0;
	eth_rx_pkg::rx_beat_t held_beat;

	gmii_rx_mac
	#(
		.LOG2_DEPTH (LOG2_DEPTH)
	) dut_i (
		.eth_clk       (eth_clk),
		.eth_sresetn   (eth_sresetn),
		.i_rxd         (i_rxd),
		.i_rxdv        (i_rxdv),
		.i_rxer        (i_rxer),
		.o_beat        (o_beat),
		.o_valid       (o_valid),
		.i_ready       (i_ready),
		.o_frame_count (o_frame_count),
		.o_drop_count  (o_drop_count)
	);

	initial
	begin
		eth_clk = 1'b0;
		forever #20 eth_clk = ~eth_clk;
	end

	task automatic stop_with_failure(input string msg);
		begin
			$display("%s", msg);
			$display("Result: FAILED");
			$fatal(1, "simulation stopped at the first error");
		end
	endtask

	// Data bytes outside keep are not part of the frame
	task automatic check_beat(input eth_rx_pkg::rx_beat_t got, input eth_rx_pkg::rx_beat_t exp,
		input string what);
		logic [NB*8-1:0] mask;
		int              j;
		begin
			mask = '0;
			for (j = 0; j < NB; j++)
				if (exp.keep[j])
					mask[j*8 +: 8] = 8'hff;
			if (((got.data & mask) !== (exp.data & mask)) || (got.keep !== exp.keep) ||
				(got.last !== exp.last))
				stop_with_failure($sformatf(
					"** Error at time %0t: %s, got data %h keep %b last %b, expected %h %b %b",
					$time, what, got.data, got.keep, got.last, exp.data, exp.keep, exp.last));
		end
	endtask

	task automatic check_count(input logic [15:0] got, input logic [15:0] exp, input string what);
		begin
			if (got !== exp)
				stop_with_failure($sformatf("** Error at time %0t: %s is %0d, expected %0d",
					$time, what, got, exp));
		end
	endtask

	function automatic int rand_range(input int lo, input int hi);
		int r;
		begin
			r = $random(seed);
			return lo + ((r & 32'h7fffffff) % (hi - lo + 1));
		end
	endfunction

	task automatic drive_gmii(input logic [7:0] d, input logic dv, input logic er);
		begin
			@(posedge eth_clk);
			i_rxd  <= d;
			i_rxdv <= dv;
			i_rxer <= er;
		end
	endtask

	// Waits until at most max_beats expected beats are still undelivered
	task automatic wait_room(input int max_beats);
		int cycles;
		begin
			cycles = 0;
			while (((exp_q.size() - taken) > max_beats) && (cycles < TIMEOUT))
			begin
				@(posedge eth_clk);
				cycles++;
			end
			if ((exp_q.size() - taken) > max_beats)
				stop_with_failure("Timeout: expected beats were never delivered");
		end
	endtask

	// Drain, then let the framer and buffer pipeline settle the counters
	task automatic wait_drain();
		begin
			wait_room(0);
			repeat (4) @(posedge eth_clk);
		end
	endtask

	// Builds one frame, updates the model and drives it onto GMII
	task automatic run_frame(input int kind, input bit limit_space);
		int                   len;
		int                   plen;
		int                   nbeats;
		int                   pos;
		int                   i;
		int                   j;
		logic [7:0]           pre[$];
		logic [7:0]           data[$];
		logic [7:0]           b;
		eth_rx_pkg::rx_beat_t beat;
		begin
			len  = rand_range(1, MAX_LEN);
			plen = rand_range(1, 7);
			// Mid-preamble corruption needs a byte after the first
			if ((kind == K_BAD_MID) && (plen < 2))
				plen = 2;
			for (i = 0; i < plen; i++)
				pre.push_back(eth_rx_pkg::PREAMBLE_BYTE);
			if (kind != K_NO_SFD)
				pre.push_back(eth_rx_pkg::SFD_BYTE);
			for (i = 0; i < len; i++)
			begin
				b = 8'(rand_range(0, 255));
				// A data byte equal to the SFD would start a frame late
				if ((kind == K_NO_SFD) && (b == eth_rx_pkg::SFD_BYTE))
					b = 8'hd4;
				data.push_back(b);
			end
			if (kind == K_BAD_FIRST)
			begin
				b = 8'(rand_range(0, 255));
				pre[0] = (b == eth_rx_pkg::PREAMBLE_BYTE) ? 8'h54 : b;
			end
			if (kind == K_BAD_MID)
			begin
				b = 8'(rand_range(0, 255));
				if ((b == eth_rx_pkg::PREAMBLE_BYTE) || (b == eth_rx_pkg::SFD_BYTE))
					b = 8'h00;
				pre[rand_range(1, plen - 1)] = b;
			end
			// Data byte that carries the receive error
			pos    = rand_range(0, len - 1);
			nbeats = (len + NB - 1) / NB;

			if (kind == K_GOOD)
			begin
				if (!limit_space || (space_used + nbeats <= DEPTH))
				begin
					// Byte 0 lowest, keep filled from bit 0, last on the final beat
					for (i = 0; i < len; i += NB)
					begin
						beat = '0;
						for (j = 0; j < NB; j++)
						begin
							if (i + j < len)
							begin
								beat.data[j*8 +: 8] = data[i + j];
								beat.keep[j]        = 1'b1;
							end
						end
						beat.last = (i + NB >= len);
						exp_q.push_back(beat);
					end
					exp_frames = exp_frames + 16'd1;
					if (limit_space)
					begin
						space_used += nbeats;
						// First beat moves on into the empty output register
						if (!out_reg_used)
						begin
							out_reg_used = 1'b1;
							space_used -= 1;
						end
					end
				end
				else
					exp_drops = exp_drops + 16'd1;
			end
			else if (kind == K_RXERR)
				exp_drops = exp_drops + 16'd1;
			// Malformed preambles are neither delivered nor counted
			sent_beats += nbeats;

			for (i = 0; i < pre.size(); i++)
				drive_gmii(pre[i], 1'b1, 1'b0);
			for (i = 0; i < len; i++)
				drive_gmii(data[i], 1'b1, (kind == K_RXERR) && (i == pos));
			repeat (rand_range(2, 5)) drive_gmii(8'h00, 1'b0, 1'b0);
		end
	endtask

	// Downstream ready
	initial
	begin
		i_ready <= 1'b0;
		forever
		begin
			@(posedge eth_clk);
			ready_rnd = $random(ready_seed);
			if (ready_mode == READY_RANDOM)
				i_ready <= ready_rnd[0];
			else
				i_ready <= (ready_mode == READY_HIGH);
		end
	end

	// Output monitor
	always @(posedge eth_clk)
	begin
		if (eth_sresetn)
		begin
			if (held_valid)
				check_beat(o_beat, held_beat, "beat changed while stalled");
			if (o_valid && i_ready)
			begin
				if (taken >= exp_q.size())
					stop_with_failure("A beat was delivered that the model did not expect");
				else
				begin
					check_beat(o_beat, exp_q[taken], "delivered beat");
					taken++;
				end
			end
			held_valid = o_valid && !i_ready;
			held_beat  = o_beat;
		end
	end

	initial
	begin
		int n;

		eth_sresetn <= 1'b0;
		i_rxd       <= 8'h00;
		i_rxdv      <= 1'b0;
		i_rxer      <= 1'b0;
		exp_frames   = '0;
		exp_drops    = '0;
		space_used   = 0;
		out_reg_used = 1'b0;
		sent_beats   = 0;
		repeat (4) @(posedge eth_clk);
		eth_sresetn <= 1'b1;
		@(posedge eth_clk);
		check_count(o_frame_count, 16'd0, "frame count after reset");
		check_count(o_drop_count, 16'd0, "drop count after reset");

		// Good frames in order under random back-pressure
		for (n = 0; n < 12; n++)
		begin
			wait_room(ROOM);
			run_frame(K_GOOD, 1'b0);
		end
		wait_drain();
		check_count(o_frame_count, exp_frames, "frame count after good frames");

		// Bad first byte, corrupt preamble and missing SFD between good frames
		for (n = 0; n < 12; n++)
		begin
			wait_room(ROOM);
			run_frame((n % 2 == 0) ? K_GOOD : K_BAD_FIRST + (n / 2) % 3, 1'b0);
		end
		wait_drain();
		check_count(o_drop_count, exp_drops, "drop count after malformed preambles");
		check_count(o_frame_count, exp_frames, "frame count after malformed preambles");

		// Receive errors
		for (n = 0; n < 10; n++)
		begin
			wait_room(ROOM);
			run_frame((n % 2 == 1) ? K_RXERR : K_GOOD, 1'b0);
		end
		wait_drain();
		check_count(o_drop_count, exp_drops, "drop count after receive errors");
		check_count(o_frame_count, exp_frames, "frame count after receive errors");

		// Random mix of every kind
		for (n = 0; n < 30; n++)
		begin
			wait_room(ROOM);
			run_frame(rand_range(K_GOOD, K_NO_SFD), 1'b0);
		end
		wait_drain();
		check_count(o_drop_count, exp_drops, "drop count after mixed frames");
		check_count(o_frame_count, exp_frames, "frame count after mixed frames");

		// Overflow with ready held low
		// The output register holds one beat beyond the buffer depth
		ready_mode   = READY_LOW;
		stall_frames = exp_frames;
		sent_beats   = 0;
		while (sent_beats <= DEPTH + 1)
			run_frame(K_GOOD, 1'b1);
		repeat (4) @(posedge eth_clk);
		check_count(o_drop_count, exp_drops, "drop count after overflow");
		check_count(o_frame_count, stall_frames, "frame count while stalled");
		ready_mode = READY_HIGH;
		wait_drain();
		check_count(o_frame_count, exp_frames, "frame count after overflow");

		if (taken == exp_q.size())
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
			stop_with_failure("Expected beats remain undelivered at the end of the run");
	end

endmodule

// File: hdl/eth_rx_pkg.sv
// ----------------------------
// Shared beat types and GMII framing constants for the receive MAC
// Referenced by scoped name from every block
// ----------------------------
package eth_rx_pkg;

	// Bytes packed into one output beat
	localparam int RX_BYTES = 2;

	// Preamble filler byte, repeated before the SFD
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;

	// Start-of-frame delimiter, the last byte before frame data
	localparam logic [7:0] SFD_BYTE = 8'hD5;

	// One beat of frame data
	// Byte 0 sits in data[7:0] and is the earliest received byte
	// Keep fills from bit 0 upward, so a partial beat is always low-aligned
	typedef struct packed
	{
		logic [RX_BYTES*8-1:0] data;
		logic [RX_BYTES-1:0]   keep;
		logic                  last;
	} rx_beat_t;

	// Write port payload from the framer into the packet buffer
	// Error marks the beat that closed a frame because of a receive error
	typedef struct packed
	{
		rx_beat_t beat;
		logic     error;
	} rx_wr_t;

endpackage

// File: hdl/gmii_rx_framer.sv
// ----------------------------
// GMII receive framer: strips preamble and SFD, packs bytes into beats
// Feeds the packet buffer through a plain write strobe
// ----------------------------
module gmii_rx_framer
(
	input  logic               eth_clk,
	input  logic               eth_sresetn,

	input  logic [7:0]         i_rxd,
	input  logic               i_rxdv,
	input  logic               i_rxer,

	output eth_rx_pkg::rx_wr_t o_wr,
	output logic               o_wr_valid
);

	localparam int NB    = eth_rx_pkg::RX_BYTES;
	localparam int DW    = 8 * NB;
	localparam int CTR_W = (NB > 1) ? $clog2(NB) : 1;

	// Byte slot of the final byte in a beat
	localparam logic [CTR_W-1:0] CTR_MAX = CTR_W'(NB - 1);

	typedef enum logic [1:0]
	{
		ST_WAIT_IDLE,
		ST_PREAMBLE,
		ST_SFD,
		ST_DATA
	} state_t;

	state_t state;

	// GMII input register stage
	logic [7:0] rx_data;
	logic       rx_valid;
	logic       rx_error;

	// High while the registered byte is the final one of the frame
	logic rx_last;

	// Slot of the next byte within the beat being filled
	logic [CTR_W-1:0] ctr;

	// Payload needs no reset
	always_ff @(posedge eth_clk)
	begin
		rx_data <= i_rxd;
	end

	always_ff @(posedge eth_clk)
	begin
		if (!eth_sresetn)
		begin
			rx_valid <= 1'b0;
			rx_error <= 1'b0;
		end
		else
		begin
			rx_valid <= i_rxdv;
			rx_error <= i_rxer;
		end
	end

	// Data valid already low on the live input, so the registered byte ends the frame
	assign rx_last = !i_rxdv;

	always_ff @(posedge eth_clk)
	begin
		if (!eth_sresetn)
		begin
			state      <= ST_WAIT_IDLE;
			ctr        <= '0;
			o_wr_valid <= 1'b0;
		end
		else
		begin
			// Strobe is a single-cycle pulse per beat
			o_wr_valid <= 1'b0;

			case (state)
				// Let the current burst run out before looking for a new frame
				ST_WAIT_IDLE:
				begin
					if (!rx_valid)
					begin
						state <= ST_PREAMBLE;
					end
				end

				// First valid byte after idle has to be preamble
				ST_PREAMBLE:
				begin
					if (rx_valid)
					begin
						if ((rx_data == eth_rx_pkg::PREAMBLE_BYTE) && !rx_error)
						begin
							state <= ST_SFD;
						end
						else
						begin
							state <= ST_WAIT_IDLE;
						end
					end
				end

				// More preamble is allowed until the SFD shows up
				ST_SFD:
				begin
					if (!rx_valid || rx_error)
					begin
						state <= ST_WAIT_IDLE;
					end
					else if (rx_data == eth_rx_pkg::SFD_BYTE)
					begin
						ctr <= '0;
						// SFD with nothing behind it is an empty frame, drop silently
						state <= rx_last ? ST_PREAMBLE : ST_DATA;
					end
					else if (rx_data != eth_rx_pkg::PREAMBLE_BYTE)
					begin
						state <= ST_WAIT_IDLE;
					end
				end

				ST_DATA:
				begin
					if (!rx_valid)
					begin
						// Should not occur, rx_last normally closes the frame first
						state <= ST_PREAMBLE;
					end
					else
					begin
						// First byte of a beat clears the rest of the beat
						if (ctr == '0)
						begin
							o_wr.beat.data <= DW'(rx_data);
							o_wr.beat.keep <= NB'(1);
						end
						else
						begin
							o_wr.beat.data[{ctr, 3'b000} +: 8] <= rx_data;
							o_wr.beat.keep[ctr]                <= 1'b1;
						end

						o_wr.beat.last <= rx_last || rx_error;
						o_wr.error     <= rx_error;

						// Push on full beat, end of frame or error
						o_wr_valid <= rx_last || rx_error || (ctr == CTR_MAX);

						ctr <= (ctr == CTR_MAX) ? '0 : ctr + 1'b1;

						// After an error the rest of the burst is ignored
						if (rx_error)
						begin
							state <= ST_WAIT_IDLE;
						end
						else if (rx_last)
						begin
							state <= ST_PREAMBLE;
						end
					end
				end

				default:
				begin
					state <= ST_WAIT_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hdl/gmii_rx_mac.sv
// ----------------------------
// Gigabit Ethernet receive MAC top level
// GMII bytes in, buffered whole frames out as a valid/ready beat stream
// ----------------------------
module gmii_rx_mac
#(
	// Buffer depth in beats as a power of two, 10 covers a 1522 byte frame
	parameter int LOG2_DEPTH = 10
)
(
	input  logic                 eth_clk,
	input  logic                 eth_sresetn,

	input  logic [7:0]           i_rxd,
	input  logic                 i_rxdv,
	input  logic                 i_rxer,

	output eth_rx_pkg::rx_beat_t o_beat,
	output logic                 o_valid,
	input  logic                 i_ready,

	output logic [15:0]          o_frame_count,
	output logic [15:0]          o_drop_count
);

	// Framer to buffer
	eth_rx_pkg::rx_wr_t   wr;
	logic                 wr_valid;

	// Buffer to output stage
	eth_rx_pkg::rx_beat_t rd;
	logic                 rd_valid;
	logic                 rd_ready;

	gmii_rx_framer framer_i
	(
		.eth_clk     (eth_clk),
		.eth_sresetn (eth_sresetn),
		.i_rxd       (i_rxd),
		.i_rxdv      (i_rxdv),
		.i_rxer      (i_rxer),
		.o_wr        (wr),
		.o_wr_valid  (wr_valid)
	);

	rx_frame_buffer
	#(
		.T_BEAT     (eth_rx_pkg::rx_beat_t),
		.LOG2_DEPTH (LOG2_DEPTH)
	) buffer_i (
		.eth_clk      (eth_clk),
		.eth_sresetn  (eth_sresetn),
		.i_wr         (wr),
		.i_wr_valid   (wr_valid),
		.o_rd         (rd),
		.o_rd_valid   (rd_valid),
		.i_rd_ready   (rd_ready),
		.o_drop_count (o_drop_count)
	);

	rx_stream_out out_i
	(
		.eth_clk       (eth_clk),
		.eth_sresetn   (eth_sresetn),
		.i_rd          (rd),
		.i_rd_valid    (rd_valid),
		.o_rd_ready    (rd_ready),
		.o_beat        (o_beat),
		.o_valid       (o_valid),
		.i_ready       (i_ready),
		.o_frame_count (o_frame_count)
	);

endmodule

// File: hdl/rx_frame_buffer.sv
// ----------------------------
// Packet buffer: holds each frame until its last beat, then commits or drops it
// Write side has no back-pressure, read side is valid/ready
// ----------------------------
module rx_frame_buffer
#(
	parameter type T_BEAT     = eth_rx_pkg::rx_beat_t,
	parameter int  LOG2_DEPTH = 10
)
(
	input  logic               eth_clk,
	input  logic               eth_sresetn,

	input  eth_rx_pkg::rx_wr_t i_wr,
	input  logic               i_wr_valid,

	output T_BEAT              o_rd,
	output logic               o_rd_valid,
	input  logic               i_rd_ready,

	output logic [15:0]        o_drop_count
);

	localparam int DEPTH = 1 << LOG2_DEPTH;

	// Beat storage
	T_BEAT mem [DEPTH];

	// Pointers carry one extra wrap bit to tell full from empty
	// wr_ptr runs ahead through the frame still arriving
	// commit_ptr marks the end of the last whole frame
	logic [LOG2_DEPTH:0] wr_ptr;
	logic [LOG2_DEPTH:0] commit_ptr;
	logic [LOG2_DEPTH:0] rd_ptr;

	// No room left, uncommitted beats included
	logic full;

	// Current frame already lost a beat or saw an error
	logic frame_bad;

	// Decision taken at the last beat of a frame
	logic drop;

	logic rd_take;

	assign full = (wr_ptr[LOG2_DEPTH] != rd_ptr[LOG2_DEPTH]) &&
		(wr_ptr[LOG2_DEPTH-1:0] == rd_ptr[LOG2_DEPTH-1:0]);

	// A last beat that does not fit also spoils the frame
	assign drop = frame_bad || full || i_wr.error;

	// Beats beyond capacity are simply not stored
	always_ff @(posedge eth_clk)
	begin
		if (i_wr_valid && !full)
		begin
			mem[wr_ptr[LOG2_DEPTH-1:0]] <= i_wr.beat;
		end
	end

	// Write side pointer handling and frame decision
	always_ff @(posedge eth_clk)
	begin
		if (!eth_sresetn)
		begin
			wr_ptr       <= '0;
			commit_ptr   <= '0;
			frame_bad    <= 1'b0;
			o_drop_count <= '0;
		end
		else if (i_wr_valid)
		begin
			if (i_wr.beat.last)
			begin
				frame_bad <= 1'b0;
				if (drop)
				begin
					// Rewind to the frame start and forget it
					wr_ptr       <= commit_ptr;
					o_drop_count <= o_drop_count + 1'b1;
				end
				else
				begin
					// Whole frame becomes visible to the reader
					wr_ptr     <= wr_ptr + 1'b1;
					commit_ptr <= wr_ptr + 1'b1;
				end
			end
			else
			begin
				// Accumulate problems until the frame ends
				frame_bad <= frame_bad || full || i_wr.error;
				if (!full)
				begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
		end
	end

	// Reader sees committed beats only
	assign o_rd_valid = (rd_ptr != commit_ptr);
	assign o_rd       = mem[rd_ptr[LOG2_DEPTH-1:0]];
	assign rd_take    = o_rd_valid && i_rd_ready;

	always_ff @(posedge eth_clk)
	begin
		if (!eth_sresetn)
		begin
			rd_ptr <= '0;
		end
		else if (rd_take)
		begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

// File: hdl/rx_stream_out.sv
// ----------------------------
// Output register stage for the beat stream, with a delivered-frame count
// ----------------------------
module rx_stream_out
(
	input  logic                 eth_clk,
	input  logic                 eth_sresetn,

	input  eth_rx_pkg::rx_beat_t i_rd,
	input  logic                 i_rd_valid,
	output logic                 o_rd_ready,

	output eth_rx_pkg::rx_beat_t o_beat,
	output logic                 o_valid,
	input  logic                 i_ready,

	output logic [15:0]          o_frame_count
);

	// Beat leaves the register this cycle
	logic take;

	assign take = o_valid && i_ready;

	// Accept upstream when empty or being drained, so no bubble between beats
	assign o_rd_ready = !o_valid || i_ready;

	always_ff @(posedge eth_clk)
	begin
		if (!eth_sresetn)
		begin
			o_valid       <= 1'b0;
			o_frame_count <= '0;
		end
		else
		begin
			if (o_rd_ready)
			begin
				o_valid <= i_rd_valid;
			end
			// One frame per accepted last beat
			if (take && o_beat.last)
			begin
				o_frame_count <= o_frame_count + 1'b1;
			end
		end
	end

	// Beat held while stalled
	always_ff @(posedge eth_clk)
	begin
		if (o_rd_ready && i_rd_valid)
		begin
			o_beat <= i_rd;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the receive MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module gmii_rx_mac_tb -f sim.f \
	-Mdir obj_dir -o gmii_rx_mac_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile step failed"
	exit 1
fi

./obj_dir/gmii_rx_mac_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
	echo "Testbench reported a failure, see $LOG"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "Simulation finished with no failure reported"
exit 0

// File: sim.f
hdl/eth_rx_pkg.sv
hdl/gmii_rx_framer.sv
hdl/rx_frame_buffer.sv
hdl/rx_stream_out.sv
hdl/gmii_rx_mac.sv
bench/gmii_rx_mac_sva.sv
bench/gmii_rx_mac_tb.sv
